//--- logic/rv_core_pkg.sv
package rv_core_pkg;

	localparam int xlen = 64;
	localparam int addr_w = 64;
	localparam int reg_idx_w = 5;

	localparam logic [31:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0
	localparam logic [6:0] trap_opcode = 7'h6b;

	localparam logic [6:0] op_reg = 7'h33;
	localparam logic [6:0] op_imm = 7'h13;
	localparam logic [6:0] op_lui = 7'h37;
	localparam logic [6:0] op_auipc = 7'h17;
	localparam logic [6:0] op_jal = 7'h6f;
	localparam logic [6:0] op_branch = 7'h63;

	// branch kind carried from decode to execute
	localparam logic [1:0] br_none = 2'd0;
	localparam logic [1:0] br_eq = 2'd1;
	localparam logic [1:0] br_ne = 2'd2;
	localparam logic [1:0] br_lt = 2'd3;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b // lui
	} alu_op_t;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_view;
		struct packed {
			logic [19:0] imm; // upper immediate of lui and auipc
			logic [4:0] rd;
			logic [6:0] opcode;
		} u_view;
	} instr_word_t;

endpackage

//--- logic/pipe_ifaces.sv
`timescale 1ns/1ns

interface issue_if;
	logic valid;
	logic [rv_core_pkg::addr_w-1:0] pc;
	logic [31:0] instr;
	rv_core_pkg::alu_op_t alu_op;
	logic [rv_core_pkg::xlen-1:0] operand_a;
	logic [rv_core_pkg::xlen-1:0] operand_b;
	logic [rv_core_pkg::xlen-1:0] rs2_value; // branch compare source
	logic [rv_core_pkg::reg_idx_w-1:0] rd;
	logic reg_wen;
	logic [1:0] branch_kind;
	logic jump;
	logic [rv_core_pkg::addr_w-1:0] target_offset;

	modport decode (output valid, pc, instr, alu_op, operand_a, operand_b, rs2_value,
		rd, reg_wen, branch_kind, jump, target_offset);
	modport execute (input valid, pc, instr, alu_op, operand_a, operand_b, rs2_value,
		rd, reg_wen, branch_kind, jump, target_offset);
endinterface

interface retire_if;
	logic valid;
	logic [rv_core_pkg::addr_w-1:0] pc;
	logic [31:0] instr;
	logic [rv_core_pkg::reg_idx_w-1:0] rd;
	logic reg_wen;
	logic [rv_core_pkg::xlen-1:0] data;

	modport execute (output valid, pc, instr, rd, reg_wen, data);
	modport writeback (input valid, pc, instr, rd, reg_wen, data);
endinterface

interface bypass_if;
	logic valid;
	logic [rv_core_pkg::reg_idx_w-1:0] rd;
	logic wen;
	logic [rv_core_pkg::xlen-1:0] data;

	modport driver (output valid, rd, wen, data);
	modport reader (input valid, rd, wen, data);
endinterface

//--- logic/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
	parameter logic [rv_core_pkg::addr_w-1:0] reset_pc = 64'h8000_0000
) (
	input  logic clock,
	input  logic reset,
	output logic ar_valid,
	input  logic ar_ready,
	output logic [rv_core_pkg::addr_w-1:0] ar_addr,
	input  logic r_valid,
	output logic r_ready,
	input  logic [rv_core_pkg::xlen-1:0] r_data,
	input  logic redirect_valid,
	input  logic [rv_core_pkg::addr_w-1:0] redirect_target,
	output logic fetch_valid,
	output logic [rv_core_pkg::addr_w-1:0] fetch_pc,
	output logic [31:0] fetch_instr
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_addr = 2'd1;
	localparam logic [1:0] st_wait = 2'd2;

	logic [1:0] state;
	logic [rv_core_pkg::addr_w-1:0] pc;
	logic discard; // response in flight belongs to a squashed path
	logic r_done;

	assign ar_valid = state == st_addr;
	assign r_ready = state == st_wait;
	assign r_done = r_ready && r_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			pc <= reset_pc;
			discard <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= r_done && !discard && !redirect_valid;
			case (state)
				st_idle: state <= st_addr;
				st_addr: if (ar_ready) state <= st_wait;
				st_wait: if (r_valid) state <= st_idle;
				default: state <= st_idle;
			endcase
			if (redirect_valid) begin
				pc <= redirect_target;
				discard <= (state == st_addr) || (r_ready && !r_valid);
			end else if (r_done) begin
				if (!discard)
					pc <= ar_addr + rv_core_pkg::addr_w'(4);
				discard <= 1'b0;
			end
		end
	end

	// address held stable from idle until the ar handshake
	always_ff @(posedge clock) begin
		if (state == st_idle)
			ar_addr <= redirect_valid ? redirect_target : pc;
		if (r_done) begin
			fetch_pc <= ar_addr;
			fetch_instr <= ar_addr[2] ? r_data[63:32] : r_data[31:0];
		end
	end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
	input  logic clock,
	input  logic reset,
	input  logic fetch_valid,
	input  logic [rv_core_pkg::addr_w-1:0] fetch_pc,
	input  logic [31:0] fetch_instr,
	input  logic redirect_valid,
	output logic [rv_core_pkg::reg_idx_w-1:0] rs1_index,
	output logic [rv_core_pkg::reg_idx_w-1:0] rs2_index,
	input  logic [rv_core_pkg::xlen-1:0] rs1_value,
	input  logic [rv_core_pkg::xlen-1:0] rs2_value,
	issue_if.decode issue,
	bypass_if.reader ex_bypass,
	bypass_if.reader wb_bypass
);

	localparam int xlen = rv_core_pkg::xlen;

	rv_core_pkg::instr_word_t word;
	logic [6:0] opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [xlen-1:0] imm_i, imm_b, imm_j, imm_u;
	logic ex_hit1, ex_hit2, wb_hit1, wb_hit2;
	logic [xlen-1:0] rs1_fwd, rs2_fwd;
	rv_core_pkg::alu_op_t alu_op;
	logic [xlen-1:0] operand_a, operand_b;
	logic [rv_core_pkg::addr_w-1:0] target_offset;
	logic reg_wen, jump;
	logic [1:0] branch_kind;

	function automatic rv_core_pkg::alu_op_t alu_func(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: alu_func = alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
			3'b010: alu_func = rv_core_pkg::alu_slt;
			3'b100: alu_func = rv_core_pkg::alu_xor;
			3'b110: alu_func = rv_core_pkg::alu_or;
			3'b111: alu_func = rv_core_pkg::alu_and;
			default: alu_func = rv_core_pkg::alu_add;
		endcase
	endfunction

	assign word = (fetch_valid && !redirect_valid) ? fetch_instr : rv_core_pkg::nop_instr;
	assign opcode = word.r_view.opcode;
	assign funct7 = word.r_view.funct7;
	assign funct3 = word.r_view.funct3;
	assign rd = word.r_view.rd;
	assign rs1 = word.r_view.rs1;
	assign rs2 = word.r_view.rs2;

	assign imm_i = {{(xlen-12){funct7[6]}}, funct7, rs2};
	assign imm_b = {{(xlen-13){funct7[6]}}, funct7[6], rd[0], funct7[5:0], rd[4:1], 1'b0};
	assign imm_j = {{(xlen-21){funct7[6]}}, funct7[6], rs1, funct3, rs2[0], funct7[5:0],
		rs2[4:1], 1'b0};
	assign imm_u = {{(xlen-32){word.u_view.imm[19]}}, word.u_view.imm, 12'b0};

	// trap reports x10
	assign rs1_index = (opcode == rv_core_pkg::trap_opcode) ? 5'd10 : rs1;
	assign rs2_index = rs2;

	// execute result wins over writeback
	assign ex_hit1 = ex_bypass.valid && ex_bypass.wen && ex_bypass.rd == rs1_index;
	assign ex_hit2 = ex_bypass.valid && ex_bypass.wen && ex_bypass.rd == rs2_index;
	assign wb_hit1 = wb_bypass.valid && wb_bypass.wen && wb_bypass.rd == rs1_index;
	assign wb_hit2 = wb_bypass.valid && wb_bypass.wen && wb_bypass.rd == rs2_index;
	assign rs1_fwd = (rs1_index == '0) ? '0 : ex_hit1 ? ex_bypass.data :
		wb_hit1 ? wb_bypass.data : rs1_value;
	assign rs2_fwd = (rs2_index == '0) ? '0 : ex_hit2 ? ex_bypass.data :
		wb_hit2 ? wb_bypass.data : rs2_value;

	always_comb begin
		alu_op = rv_core_pkg::alu_add;
		operand_a = rs1_fwd;
		operand_b = '0;
		target_offset = '0;
		reg_wen = 1'b0;
		jump = 1'b0;
		branch_kind = rv_core_pkg::br_none;
		case (opcode)
			rv_core_pkg::op_reg: begin
				alu_op = alu_func(funct3, funct7[5]);
				operand_b = rs2_fwd;
				reg_wen = 1'b1;
			end
			rv_core_pkg::op_imm: begin
				alu_op = alu_func(funct3, 1'b0);
				operand_b = imm_i;
				reg_wen = 1'b1;
			end
			rv_core_pkg::op_lui: begin
				alu_op = rv_core_pkg::alu_pass_b;
				operand_b = imm_u;
				reg_wen = 1'b1;
			end
			rv_core_pkg::op_auipc: begin
				operand_a = fetch_pc;
				operand_b = imm_u;
				reg_wen = 1'b1;
			end
			rv_core_pkg::op_jal: begin
				operand_a = fetch_pc;
				operand_b = xlen'(4); // link value
				target_offset = imm_j;
				jump = 1'b1;
				reg_wen = 1'b1;
			end
			rv_core_pkg::op_branch: begin
				operand_b = rs2_fwd;
				target_offset = imm_b;
				case (funct3)
					3'b000: branch_kind = rv_core_pkg::br_eq;
					3'b001: branch_kind = rv_core_pkg::br_ne;
					3'b100: branch_kind = rv_core_pkg::br_lt;
					default: branch_kind = rv_core_pkg::br_none;
				endcase
			end
			default: reg_wen = 1'b0; // trap and unknown opcodes pass rs1 through
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			issue.valid <= 1'b0;
		else
			issue.valid <= fetch_valid && !redirect_valid;
	end

	always_ff @(posedge clock) begin
		issue.pc <= fetch_pc;
		issue.instr <= word;
		issue.alu_op <= alu_op;
		issue.operand_a <= operand_a;
		issue.operand_b <= operand_b;
		issue.rs2_value <= rs2_fwd;
		issue.rd <= rd;
		issue.reg_wen <= reg_wen && (rd != '0);
		issue.branch_kind <= branch_kind;
		issue.jump <= jump;
		issue.target_offset <= target_offset;
	end

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ns

module register_file (
	input  logic clock,
	input  logic reset,
	input  logic [rv_core_pkg::reg_idx_w-1:0] rs1_index,
	input  logic [rv_core_pkg::reg_idx_w-1:0] rs2_index,
	output logic [rv_core_pkg::xlen-1:0] rs1_value,
	output logic [rv_core_pkg::xlen-1:0] rs2_value,
	input  logic write_en,
	input  logic [rv_core_pkg::reg_idx_w-1:0] write_index,
	input  logic [rv_core_pkg::xlen-1:0] write_data
);

	logic [rv_core_pkg::xlen-1:0] regs [0:31];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (write_en && write_index != '0) begin
			regs[write_index] <= write_data; // x0 never written
		end
	end

	assign rs1_value = regs[rs1_index];
	assign rs2_value = regs[rs2_index];

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
	input  logic clock,
	input  logic reset,
	issue_if.execute issue,
	retire_if.execute retire,
	bypass_if.driver ex_bypass,
	output logic redirect_valid,
	output logic [rv_core_pkg::addr_w-1:0] redirect_target
);

	logic [rv_core_pkg::xlen-1:0] result;
	logic taken;

	always_comb begin
		case (issue.alu_op)
			rv_core_pkg::alu_add: result = issue.operand_a + issue.operand_b;
			rv_core_pkg::alu_sub: result = issue.operand_a - issue.operand_b;
			rv_core_pkg::alu_and: result = issue.operand_a & issue.operand_b;
			rv_core_pkg::alu_or: result = issue.operand_a | issue.operand_b;
			rv_core_pkg::alu_xor: result = issue.operand_a ^ issue.operand_b;
			rv_core_pkg::alu_slt: begin
				result = {{(rv_core_pkg::xlen-1){1'b0}},
					$signed(issue.operand_a) < $signed(issue.operand_b)};
			end
			rv_core_pkg::alu_pass_b: result = issue.operand_b;
			default: result = issue.operand_a + issue.operand_b;
		endcase
	end

	always_comb begin
		case (issue.branch_kind)
			rv_core_pkg::br_eq: taken = issue.operand_a == issue.rs2_value;
			rv_core_pkg::br_ne: taken = issue.operand_a != issue.rs2_value;
			rv_core_pkg::br_lt: taken = $signed(issue.operand_a) < $signed(issue.rs2_value);
			default: taken = 1'b0;
		endcase
	end

	assign redirect_valid = issue.valid && (issue.jump || taken);
	assign redirect_target = issue.pc + issue.target_offset;

	assign ex_bypass.valid = issue.valid;
	assign ex_bypass.rd = issue.rd;
	assign ex_bypass.wen = issue.reg_wen;
	assign ex_bypass.data = result;

	always_ff @(posedge clock) begin
		if (reset)
			retire.valid <= 1'b0;
		else
			retire.valid <= issue.valid;
	end

	always_ff @(posedge clock) begin
		retire.pc <= issue.pc;
		retire.instr <= issue.instr;
		retire.rd <= issue.rd;
		retire.reg_wen <= issue.reg_wen;
		retire.data <= result;
	end

endmodule

//--- logic/writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage (
	input  logic clock,
	input  logic reset,
	retire_if.writeback retire,
	bypass_if.driver wb_bypass,
	output logic write_en,
	output logic [rv_core_pkg::reg_idx_w-1:0] write_index,
	output logic [rv_core_pkg::xlen-1:0] write_data,
	output logic commit_valid,
	output logic [rv_core_pkg::addr_w-1:0] commit_pc,
	output logic [31:0] commit_instr,
	output logic commit_wen,
	output logic [rv_core_pkg::reg_idx_w-1:0] commit_rd,
	output logic [rv_core_pkg::xlen-1:0] commit_data,
	output logic trap_valid,
	output logic [7:0] trap_code
);

	logic trapped; // sticky, blocks all later commits

	assign commit_valid = retire.valid && !trapped;
	assign commit_pc = retire.pc;
	assign commit_instr = retire.instr;
	assign commit_wen = retire.reg_wen;
	assign commit_rd = retire.rd;
	assign commit_data = retire.data;

	assign write_en = commit_valid && retire.reg_wen;
	assign write_index = retire.rd;
	assign write_data = retire.data;

	assign wb_bypass.valid = commit_valid;
	assign wb_bypass.rd = retire.rd;
	assign wb_bypass.wen = retire.reg_wen;
	assign wb_bypass.data = retire.data;

	assign trap_valid = trapped;

	always_ff @(posedge clock) begin
		if (reset) begin
			trapped <= 1'b0;
			trap_code <= '0;
		end else if (commit_valid && retire.instr[6:0] == rv_core_pkg::trap_opcode) begin
			trapped <= 1'b1;
			trap_code <= retire.data[7:0]; // low byte of x10
		end
	end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ns

module rv_core #(
	parameter logic [rv_core_pkg::addr_w-1:0] reset_pc = 64'h8000_0000
) (
	input  logic clock,
	input  logic reset,
	output logic ar_valid,
	input  logic ar_ready,
	output logic [rv_core_pkg::addr_w-1:0] ar_addr,
	input  logic r_valid,
	output logic r_ready,
	input  logic [rv_core_pkg::xlen-1:0] r_data,
	output logic commit_valid,
	output logic [rv_core_pkg::addr_w-1:0] commit_pc,
	output logic [31:0] commit_instr,
	output logic commit_wen,
	output logic [rv_core_pkg::reg_idx_w-1:0] commit_rd,
	output logic [rv_core_pkg::xlen-1:0] commit_data,
	output logic trap_valid,
	output logic [7:0] trap_code
);

	logic fetch_valid;
	logic [rv_core_pkg::addr_w-1:0] fetch_pc;
	logic [31:0] fetch_instr;
	logic redirect_valid;
	logic [rv_core_pkg::addr_w-1:0] redirect_target;
	logic [rv_core_pkg::reg_idx_w-1:0] rs1_index, rs2_index;
	logic [rv_core_pkg::xlen-1:0] rs1_value, rs2_value;
	logic write_en;
	logic [rv_core_pkg::reg_idx_w-1:0] write_index;
	logic [rv_core_pkg::xlen-1:0] write_data;

	issue_if issue ();
	retire_if retire ();
	bypass_if ex_bypass ();
	bypass_if wb_bypass ();

	fetch_unit #(.reset_pc(reset_pc)) fetch_unit_inst (
		.clock(clock), .reset(reset),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
		.r_valid(r_valid), .r_ready(r_ready), .r_data(r_data),
		.redirect_valid(redirect_valid), .redirect_target(redirect_target),
		.fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_instr(fetch_instr)
	);

	decode_stage decode_stage_inst (
		.clock(clock), .reset(reset),
		.fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_instr(fetch_instr),
		.redirect_valid(redirect_valid),
		.rs1_index(rs1_index), .rs2_index(rs2_index),
		.rs1_value(rs1_value), .rs2_value(rs2_value),
		.issue(issue.decode), .ex_bypass(ex_bypass.reader), .wb_bypass(wb_bypass.reader)
	);

	register_file register_file_inst (
		.clock(clock), .reset(reset),
		.rs1_index(rs1_index), .rs2_index(rs2_index),
		.rs1_value(rs1_value), .rs2_value(rs2_value),
		.write_en(write_en), .write_index(write_index), .write_data(write_data)
	);

	execute_stage execute_stage_inst (
		.clock(clock), .reset(reset),
		.issue(issue.execute), .retire(retire.execute), .ex_bypass(ex_bypass.driver),
		.redirect_valid(redirect_valid), .redirect_target(redirect_target)
	);

	writeback_stage writeback_stage_inst (
		.clock(clock), .reset(reset),
		.retire(retire.writeback), .wb_bypass(wb_bypass.driver),
		.write_en(write_en), .write_index(write_index), .write_data(write_data),
		.commit_valid(commit_valid), .commit_pc(commit_pc), .commit_instr(commit_instr),
		.commit_wen(commit_wen), .commit_rd(commit_rd), .commit_data(commit_data),
		.trap_valid(trap_valid), .trap_code(trap_code)
	);

endmodule

//--- test/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

//--- test/core_properties.sv
`timescale 1ns/1ns

module core_properties (
	input logic clock,
	input logic reset,
	input logic ar_valid,
	input logic ar_ready,
	input logic [rv_core_pkg::addr_w-1:0] ar_addr,
	input logic r_ready,
	input logic commit_valid,
	input logic trap_valid
);

	int failures = 0; // failed assertions so far

	quiet_after_reset: assert property (@(posedge clock)
		$past(reset) |-> !ar_valid && !r_ready && !commit_valid && !trap_valid)
		else begin
			$error("read or commit output active during or just after reset");
			failures++;
		end

	ar_held: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
		else begin
			$error("ar_valid dropped or ar_addr changed before ar_ready");
			failures++;
		end

	ar_aligned: assert property (@(posedge clock) disable iff (reset)
		ar_valid |-> ar_addr[1:0] == 2'b00)
		else begin
			$error("ar_addr is not 4-byte aligned");
			failures++;
		end

	single_read: assert property (@(posedge clock) disable iff (reset)
		r_ready |-> !ar_valid)
		else begin
			$error("new read address issued while a read is outstanding");
			failures++;
		end

	trap_sticky: assert property (@(posedge clock) disable iff (reset)
		trap_valid |=> trap_valid)
		else begin
			$error("trap_valid fell after it was raised");
			failures++;
		end

	no_commit_after_trap: assert property (@(posedge clock) disable iff (reset)
		trap_valid |-> !commit_valid)
		else begin
			$error("instruction committed after the trap");
			failures++;
		end

endmodule

//--- test/core_tb.sv
`timescale 1ns/1ns

module core_tb;

	localparam logic [63:0] boot_pc = 64'h8000_0000;
	localparam int prog_len = 29;
	localparam int watchdog_cycles = 4 + 40 * prog_len;

	logic clock, reset;
	logic ar_valid, ar_ready, r_valid, r_ready;
	logic [63:0] ar_addr, r_data;
	logic commit_valid, commit_wen, trap_valid;
	logic [63:0] commit_pc, commit_data;
	logic [31:0] commit_instr;
	logic [4:0] commit_rd;
	logic [7:0] trap_code;

	logic [31:0] program_rom [0:prog_len-1];
	logic [63:0] model_regs [0:31] = '{default: 64'd0};
	logic [63:0] model_pc = boot_pc;
	logic model_done = 1'b0;
	logic trap_check = 1'b0;
	logic [7:0] trap_code_exp;
	int commit_errors = 0;

	clock_gen clock_gen_inst (.clock(clock), .reset(reset));

	rv_core #(.reset_pc(boot_pc)) rv_core_inst (
		.clock(clock), .reset(reset),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
		.r_valid(r_valid), .r_ready(r_ready), .r_data(r_data),
		.commit_valid(commit_valid), .commit_pc(commit_pc), .commit_instr(commit_instr),
		.commit_wen(commit_wen), .commit_rd(commit_rd), .commit_data(commit_data),
		.trap_valid(trap_valid), .trap_code(trap_code)
	);

	bind rv_core core_properties core_properties_inst (
		.clock(clock), .reset(reset), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.ar_addr(ar_addr), .r_ready(r_ready), .commit_valid(commit_valid),
		.trap_valid(trap_valid)
	);

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'h13};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs1, rs2,
		input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
	endfunction

	task automatic load_program();
		program_rom[0] = enc_i(12'd5, 5'd0, 3'b000, 5'd1);
		program_rom[1] = enc_i(12'hffd, 5'd1, 3'b000, 5'd2);
		program_rom[2] = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3); // add
		program_rom[3] = enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4); // sub
		program_rom[4] = enc_r(7'h00, 5'd3, 5'd4, 3'b100, 5'd5);
		program_rom[5] = enc_r(7'h00, 5'd1, 5'd5, 3'b110, 5'd6);
		program_rom[6] = enc_r(7'h00, 5'd3, 5'd6, 3'b111, 5'd7);
		program_rom[7] = enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd8); // slt
		program_rom[8] = enc_i(12'hfff, 5'd1, 3'b010, 5'd9);
		program_rom[9] = enc_i(12'd6, 5'd3, 3'b111, 5'd11);
		program_rom[10] = enc_i(12'h040, 5'd4, 3'b110, 5'd12);
		program_rom[11] = enc_i(12'hfff, 5'd12, 3'b100, 5'd13); // x13 goes negative
		program_rom[12] = {20'h12345, 5'd14, 7'h37}; // lui
		program_rom[13] = {20'h00001, 5'd15, 7'h17}; // auipc
		program_rom[14] = enc_b(13'd8, 5'd1, 5'd1, 3'b000); // beq taken
		program_rom[15] = enc_i(12'd99, 5'd0, 3'b000, 5'd20); // squashed
		program_rom[16] = enc_b(13'd8, 5'd1, 5'd1, 3'b001); // bne not taken
		program_rom[17] = enc_b(13'd8, 5'd13, 5'd1, 3'b100); // blt taken
		program_rom[18] = enc_i(12'd77, 5'd0, 3'b000, 5'd21);
		program_rom[19] = enc_b(13'd12, 5'd1, 5'd2, 3'b100); // blt not taken
		program_rom[20] = enc_b(13'd8, 5'd1, 5'd2, 3'b000);
		program_rom[21] = enc_b(13'd8, 5'd1, 5'd2, 3'b001); // bne taken
		program_rom[22] = enc_i(12'd55, 5'd0, 3'b000, 5'd22);
		program_rom[23] = {1'b0, 10'd4, 1'b0, 8'd0, 5'd16, 7'h6f}; // jal x16, +8
		program_rom[24] = enc_i(12'd44, 5'd0, 3'b000, 5'd23);
		program_rom[25] = enc_r(7'h00, 5'd15, 5'd16, 3'b000, 5'd10);
		program_rom[26] = enc_i(12'h05a, 5'd10, 3'b100, 5'd10);
		program_rom[27] = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0); // x0 stays zero
		program_rom[28] = 32'h0000_006b; // trap
	endtask

	// outside the program an addi x0 word folded from the address
	function automatic logic [31:0] rom_word(input logic [63:0] addr);
		logic [63:0] offset;
		logic [31:0] fold;
		logic [11:0] imm;
		offset = addr - boot_pc;
		fold = addr[63:32] ^ addr[31:0];
		imm = fold[11:0] ^ fold[23:12] ^ {4'h0, fold[31:24]};
		if (addr >= boot_pc && offset < 64'(prog_len * 4))
			return program_rom[offset[7:2]];
		return {imm, 5'd0, 3'd0, 5'd0, 7'h13};
	endfunction

	function automatic logic [63:0] rom_line(input logic [63:0] addr);
		return {rom_word({addr[63:3], 3'b100}), rom_word({addr[63:3], 3'b000})};
	endfunction

	function automatic logic [63:0] alu_result(input logic [3:0] sel, input logic [63:0] a, b);
		case (sel[2:0])
			3'b000: return sel[3] ? a - b : a + b;
			3'b010: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			3'b100: return a ^ b;
			3'b110: return a | b;
			3'b111: return a & b;
			default: return a + b;
		endcase
	endfunction

	function automatic void predict(input logic [63:0] pc, input logic [31:0] ins,
		output logic wen, output logic [4:0] rd, output logic [63:0] data,
		output logic [63:0] next_pc);
		logic [63:0] a, b, imm_i, imm_b, imm_j, imm_u;
		logic taken;
		a = model_regs[ins[19:15]];
		b = model_regs[ins[24:20]];
		imm_i = {{52{ins[31]}}, ins[31:20]};
		imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
		rd = ins[11:7];
		wen = 1'b1;
		data = '0;
		taken = 1'b0;
		case (ins[6:0])
			7'h33: data = alu_result({ins[30], ins[14:12]}, a, b);
			7'h13: data = alu_result({1'b0, ins[14:12]}, a, imm_i);
			7'h37: data = imm_u;
			7'h17: data = pc + imm_u;
			7'h6f: data = pc + 64'd4; // link
			7'h63: begin
				wen = 1'b0;
				case (ins[14:12])
					3'b000: taken = a == b;
					3'b001: taken = a != b;
					3'b100: taken = $signed(a) < $signed(b);
					default: taken = 1'b0;
				endcase
			end
			7'h6b: begin
				wen = 1'b0;
				data = model_regs[10];
			end
			default: wen = 1'b0;
		endcase
		wen = wen && rd != 5'd0;
		if (ins[6:0] == 7'h6f)
			next_pc = pc + imm_j;
		else if (taken)
			next_pc = pc + imm_b;
		else
			next_pc = pc + 64'd4;
	endfunction

	task automatic note_mismatch(input string what, input logic [63:0] got,
		input logic [63:0] want);
		commit_errors++;
		$display("Fail %0t: %s is %h, expected %h", $time, what, got, want);
	endtask

	initial begin : axi_responder
		logic [63:0] read_addr;
		int ar_wait;
		int r_wait;
		logic r_pending;
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_data = '0;
		read_addr = '0;
		ar_wait = 0;
		r_wait = 0;
		r_pending = 1'b0;
		void'($urandom(32'h7135_a3c3));
		forever begin
			@(posedge clock);
			if (reset) begin
				ar_ready <= 1'b0;
				r_valid <= 1'b0;
				ar_wait = $urandom_range(3, 0);
				r_pending = 1'b0;
			end else begin
				if (ar_valid && ar_ready) begin
					read_addr = ar_addr;
					r_pending = 1'b1;
					r_wait = $urandom_range(3, 0);
					ar_wait = $urandom_range(3, 0);
					ar_ready <= (ar_wait == 0); // zero wait keeps ready up
				end else if (ar_valid) begin
					ar_wait = ar_wait - 1;
					if (ar_wait <= 0)
						ar_ready <= 1'b1;
				end
				if (r_valid && r_ready) begin
					r_valid <= 1'b0;
				end else if (r_pending && !r_valid) begin
					if (r_wait == 0) begin
						r_valid <= 1'b1;
						r_data <= rom_line(read_addr);
						r_pending = 1'b0;
					end else begin
						r_wait = r_wait - 1;
					end
				end
			end
		end
	end

	always @(posedge clock) begin : commit_checker
		logic [31:0] ins;
		logic wen;
		logic [4:0] rd;
		logic [63:0] data;
		logic [63:0] next_pc;
		if (trap_check) begin
			assert (trap_valid) else begin
				commit_errors++;
				$display("trap_valid did not rise after the trap committed");
			end
			assert (trap_code == trap_code_exp)
				else note_mismatch("trap_code", 64'(trap_code), 64'(trap_code_exp));
			trap_check = 1'b0;
		end
		if (!reset && commit_valid) begin
			if (model_done) begin
				commit_errors++;
				$display("instruction at pc %h committed after the trap", commit_pc);
			end else begin
				ins = rom_word(model_pc);
				predict(model_pc, ins, wen, rd, data, next_pc);
				assert (commit_pc == model_pc)
					else note_mismatch("commit_pc", commit_pc, model_pc);
				assert (commit_instr == ins)
					else note_mismatch("commit_instr", 64'(commit_instr), 64'(ins));
				assert (commit_wen == wen)
					else note_mismatch("commit_wen", 64'(commit_wen), 64'(wen));
				if (wen) begin
					assert (commit_rd == rd)
						else note_mismatch("commit_rd", 64'(commit_rd), 64'(rd));
					assert (commit_data == data)
						else note_mismatch("commit_data", commit_data, data);
					model_regs[rd] = data;
				end
				if (ins[6:0] == 7'h6b) begin
					assert (commit_data == data)
						else note_mismatch("trap x10", commit_data, data);
					trap_code_exp = data[7:0];
					trap_check = 1'b1;
					model_done = 1'b1;
				end
				model_pc = next_pc;
			end
		end
	end

	initial begin : watchdog
		#(watchdog_cycles * 8);
		$display("timeout after %0d cycles without reaching the trap", watchdog_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin : run_control
		int total;
		load_program();
		wait (model_done);
		repeat (20) @(posedge clock); // nothing may commit after the trap
		total = commit_errors + rv_core_inst.core_properties_inst.failures;
		$display("errors: commit checks %0d, properties %0d", commit_errors,
			rv_core_inst.core_properties_inst.failures);
		if (total == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- sources.f
logic/rv_core_pkg.sv
logic/pipe_ifaces.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/register_file.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/rv_core.sv
test/clock_gen.sv
test/core_properties.sv
test/core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns --top-module core_tb \
	-f sources.f -Mdir build -o core_sim

./build/core_sim +verilator+error+limit+1000 | tee sim.log

grep -q "ALL TESTS PASSED" sim.log
